// File: filelist.f
+incdir+include
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_retire.sv
design/rv_core.sv
bench/core_assertions.sv
bench/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f filelist.f -o sim_core \
  || { echo "build failed"; exit 1; }

./obj_dir/sim_core +verilator+error+limit+1000 > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: include/rv_encode.svh
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

// instruction assemblers for building test programs
// branch and jal offsets are in bytes, relative to the instruction itself

function automatic logic [31:0] lui_insn(input logic [4:0] rd, input logic [19:0] upper);
  return {upper, rd, rv_pkg::op_lui};
endfunction

function automatic logic [31:0] imm_insn(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, rv_pkg::op_reg_imm};
endfunction

function automatic logic [31:0] shift_insn(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] shamt);
  return {(alt ? rv_pkg::alt_funct7 : 7'd0), shamt, rs1, f3, rd, rv_pkg::op_reg_imm};
endfunction

function automatic logic [31:0] reg_insn(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
  return {(alt ? rv_pkg::alt_funct7 : 7'd0), rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
endfunction

function automatic logic [31:0] branch_insn(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
endfunction

function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
endfunction

function automatic logic [31:0] ecall_insn();
  return {25'd0, rv_pkg::op_environ};
endfunction

`endif

// File: bench/tb_core.sv
`timescale 1ns/100ps
`include "rv_encode.svh"

module tb_core import rv_pkg::*; ();

  localparam int    prog_words = 128;
  localparam word_t trap_addr  = word_t'((prog_words - 1) * 4);
  localparam int    limit      = 16 + 4 * prog_words;  // reset plus one pass of the program
  localparam int    n_sect     = 5;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  word_t    insn = '0;
  word_t    pc;
  logic     halt;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  word_t prog [0:prog_words-1];
  word_t sect_end [0:n_sect-1];
  string sect_name [0:n_sect-1] = '{"alu_imm", "alu_reg", "branch_jal", "x0_write", "illegal"};
  int    wp = 0;
  int    seed = 32'h2475;
  int    sect_done = 0;
  int    cycles = 0;
  int    fails;

  rv_core dut_i (.*);

  bind rv_core core_assertions checks_i (.*);

  always #20 clk = ~clk;

  task automatic emit(input word_t w);
    prog[wp] = w;
    wp++;
  endtask

  task automatic load_const(input logic [4:0] rd, input word_t v);
    word_t up;
    up = v + 32'h800;  // addi sign extends the low part
    emit(lui_insn(rd, up[31:12]));
    emit(imm_insn(f3_add, rd, rd, v[11:0]));
  endtask

  task automatic branch_to_trap(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2);
    word_t off;
    off = trap_addr - word_t'(wp * 4);
    emit(branch_insn(f3, rs1, rs2, off[12:0]));
  endtask

  task automatic jump_to_trap();
    word_t off;
    off = trap_addr - word_t'(wp * 4);
    emit(jal_insn(5'd0, off[20:0]));
  endtask

  // result lands in x2, expected constant in x3
  task automatic alu_check(input word_t op_word, input word_t expected);
    emit(op_word);
    load_const(5'd3, expected);
    branch_to_trap(f3_bne, 5'd2, 5'd3);
  endtask

  task automatic build_program();
    word_t              a;
    word_t              b;
    word_t              sx;
    word_t              r;
    word_t              off;
    word_t              link;
    logic signed [31:0] sa;
    logic [11:0]        i;
    logic [4:0]         sh;
    for (int k = 0; k < prog_words; k++) begin
      off = trap_addr - word_t'(k * 4);
      prog[k] = jal_insn(5'd0, off[20:0]);  // stray fetches fall into the trap
    end
    a = $random(seed);
    r = $random(seed);
    i = r[11:0];
    sx = {{20{i[11]}}, i};
    sh = r[16:12];
    sa = a;
    load_const(5'd1, a);
    alu_check(imm_insn(f3_add, 5'd2, 5'd1, i), a + sx);
    alu_check(imm_insn(f3_slt, 5'd2, 5'd1, i), word_t'($signed(a) < $signed(sx)));
    alu_check(imm_insn(f3_sltu, 5'd2, 5'd1, i), word_t'(a < sx));
    alu_check(imm_insn(f3_xor, 5'd2, 5'd1, i), a ^ sx);
    alu_check(shift_insn(f3_srl, 1'b1, 5'd2, 5'd1, sh), sa >>> sh);
    sect_end[0] = word_t'(wp * 4);
    b = $random(seed);
    load_const(5'd4, b);
    alu_check(reg_insn(f3_add, 1'b1, 5'd2, 5'd1, 5'd4), a - b);
    alu_check(reg_insn(f3_srl, 1'b1, 5'd2, 5'd1, 5'd4), sa >>> b[4:0]);
    alu_check(reg_insn(f3_slt, 1'b0, 5'd2, 5'd1, 5'd4), word_t'($signed(a) < $signed(b)));
    alu_check(reg_insn(f3_sltu, 1'b0, 5'd2, 5'd1, 5'd4), word_t'(a < b));
    alu_check(reg_insn(f3_and, 1'b0, 5'd2, 5'd1, 5'd4), a & b);
    sect_end[1] = word_t'(wp * 4);
    emit(branch_insn(f3_beq, 5'd1, 5'd1, 13'd8));  // taken so the trap jump is skipped
    jump_to_trap();
    emit(branch_insn(f3_bge, 5'd1, 5'd1, 13'd8));
    jump_to_trap();
    branch_to_trap(f3_bne, 5'd1, 5'd1);  // never taken
    link = word_t'(wp * 4) + pc_step;
    emit(jal_insn(5'd5, 21'd8));
    jump_to_trap();
    load_const(5'd6, link);
    branch_to_trap(f3_bne, 5'd5, 5'd6);
    sect_end[2] = word_t'(wp * 4);
    emit(imm_insn(f3_add, 5'd0, 5'd1, 12'h07b));
    emit(lui_insn(5'd8, 20'd0));
    branch_to_trap(f3_bne, 5'd0, 5'd8);
    sect_end[3] = word_t'(wp * 4);
    emit({20'h12345, 5'd9, 7'h0b});                          // unknown opcode
    emit({7'h11, 5'd4, 5'd1, f3_add, 5'd9, op_reg_reg});     // bad funct7
    branch_to_trap(f3_bne, 5'd9, 5'd0);                      // x9 must still be zero
    sect_end[4] = word_t'(wp * 4);
    emit(ecall_insn());
  endtask

  always @(negedge clk) begin
    insn = prog[pc[8:2]];
    if (!rst && sect_done < n_sect && pc == sect_end[sect_done]) begin
      $display("test %0d %s done", sect_done, sect_name[sect_done]);
      sect_done++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the core never halted", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    build_program();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (halt);
    prog[pc[8:2]] = lui_insn(5'd10, 20'habcde);  // a halted core must ignore a live write
    repeat (8) @(negedge clk);  // watch the halted core hold
    $display("test %0d halt done", n_sect);
    fails = dut_i.checks_i.fail_cnt;
    $display("%0d of %0d tests done, %0d assertion failures", sect_done + 1, n_sect + 1, fails);
    if (fails == 0 && sect_done == n_sect) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: bench/core_assertions.sv
`timescale 1ns/100ps

module core_assertions import rv_pkg::*; #(
  parameter word_t trap_pc = 32'h0000_01fc
) (
  input logic     clk,
  input logic     rst,
  input word_t    insn,
  input word_t    pc,
  input logic     halt,
  input logic     wb_en,
  input reg_idx_t wb_rd,
  input word_t    wb_data
);

  int      fail_cnt = 0;  // failed assertions so far
  opcode_t opcode;
  word_t   b_off;
  word_t   j_off;
  word_t   last_pc;
  word_t   last_b;
  word_t   last_j;
  logic    plain;
  logic    live;

  localparam word_t ecall_word = {25'd0, op_environ};

  assign opcode = insn[6:0];
  assign b_off  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign j_off  = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign plain  = opcode != op_branch && opcode != op_jal && insn != ecall_word;
  assign live   = !rst && !halt;

  always_ff @(posedge clk) begin
    last_pc <= pc;
    last_b  <= b_off;
    last_j  <= j_off;
  end

  a_reset_out: assert property (@(posedge clk) rst |-> !wb_en)
    else begin
      fail_cnt++;
      $error("wb_en was high during reset");
    end

  a_reset_pc: assert property (@(posedge clk) rst |=> pc == reset_pc && !halt)
    else begin
      fail_cnt++;
      $error("ERR pc %h halt %h expected pc %h halt 0 after reset", $sampled(pc),
             $sampled(halt), reset_pc);
    end

  // the program branches here when a computed value is wrong
  a_no_trap: assert property (@(posedge clk) !rst |-> pc != trap_pc)
    else begin
      fail_cnt++;
      $error("program reached the trap address, a value check failed");
    end

  a_step: assert property (@(posedge clk) live && plain |=> pc == last_pc + pc_step)
    else begin
      fail_cnt++;
      $error("ERR pc %h expected %h", $sampled(pc), $sampled(last_pc) + pc_step);
    end

  a_branch: assert property (@(posedge clk) live && opcode == op_branch |=>
                             pc == last_pc + pc_step || pc == last_pc + last_b)
    else begin
      fail_cnt++;
      $error("ERR pc %h expected %h or %h", $sampled(pc), $sampled(last_pc) + pc_step,
             $sampled(last_pc) + $sampled(last_b));
    end

  a_jal: assert property (@(posedge clk) live && opcode == op_jal |=> pc == last_pc + last_j)
    else begin
      fail_cnt++;
      $error("ERR pc %h expected %h", $sampled(pc), $sampled(last_pc) + $sampled(last_j));
    end

  a_link: assert property (@(posedge clk) live && opcode == op_jal && insn[11:7] != '0 |->
                           wb_en && wb_data == pc + pc_step)
    else begin
      fail_cnt++;
      $error("ERR wb_data %h expected %h", $sampled(wb_data), $sampled(pc) + pc_step);
    end

  a_no_x0: assert property (@(posedge clk) wb_en |-> wb_rd != '0)
    else begin
      fail_cnt++;
      $error("a write to x0 raised wb_en");
    end

  a_illegal: assert property (@(posedge clk) opcode == 7'h0b |-> !wb_en)
    else begin
      fail_cnt++;
      $error("an illegal instruction raised wb_en");
    end

  a_halt_rise: assert property (@(posedge clk) !rst && insn == ecall_word |=> halt)
    else begin
      fail_cnt++;
      $error("halt did not rise after ecall");
    end

  a_halt_hold: assert property (@(posedge clk) !rst && halt |=> halt && pc == last_pc)
    else begin
      fail_cnt++;
      $error("halt dropped or pc moved while halted");
    end

  a_halt_wb: assert property (@(posedge clk) halt |-> !wb_en)
    else begin
      fail_cnt++;
      $error("wb_en was high while halted");
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  word_t    insn,
  output word_t    pc,
  output logic     halt,
  output logic     wb_en,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic  branch_taken;

  rv_decode_if dec_if ();

  rv_decode decode_i (
    .insn (insn),
    .d    (dec_if)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .d        (dec_if),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  rv_execute execute_i (
    .d            (dec_if),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  rv_retire retire_i (
    .clk          (clk),
    .rst          (rst),
    .d            (dec_if),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .pc           (pc),
    .halt         (halt),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

endmodule

// File: design/rv_retire.sv
`timescale 1ns/100ps

module rv_retire import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  rv_decode_if.ret d,
  input  word_t    alu_result,
  input  logic     branch_taken,
  output word_t    pc,
  output logic     halt,
  output logic     wb_en,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  word_t pc_plus4;
  word_t pc_target;
  word_t next_pc;
  logic  writes_rd;

  assign pc_plus4  = pc + pc_step;
  assign pc_target = pc + d.imm;  // b or j offset

  assign writes_rd = d.op_class inside {class_lui, class_alu_imm, class_alu_reg, class_jal};

  // illegal words fall through here as a no-op
  assign wb_en   = writes_rd && (d.rd != '0) && !halt && !rst;
  assign wb_rd   = d.rd;

  always_comb begin
    case (d.op_class)
      class_lui: wb_data = d.imm;
      class_jal: wb_data = pc_plus4;  // link address
      default:   wb_data = alu_result;
    endcase
  end

  always_comb begin
    if (halt || d.op_class == class_halt) begin
      next_pc = pc;  // park on the ecall
    end else if (branch_taken || d.op_class == class_jal) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else begin
      pc <= next_pc;
      if (d.op_class == class_halt) halt <= 1'b1;  // sticky until reset
    end
  end

endmodule

// File: design/rv_execute.sv
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
  rv_decode_if.ex d,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  output word_t   alu_result,
  output logic    branch_taken
);

  word_t      op_b;
  logic [4:0] shamt;
  logic       sub_sel;
  word_t      sra_val;
  logic       cond;

  assign op_b  = (d.op_class == class_alu_imm) ? d.imm : rs2_data;
  assign shamt = op_b[4:0];

  // addi has no subtract form, bit 30 there is just immediate
  assign sub_sel = d.alt && (d.op_class == class_alu_reg);

  // kept on its own so the shift stays signed
  assign sra_val = $signed(rs1_data) >>> shamt;

  always_comb begin
    case (d.funct3)
      f3_add:  alu_result = sub_sel ? rs1_data - op_b : rs1_data + op_b;
      f3_sll:  alu_result = rs1_data << shamt;
      f3_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      f3_sltu: alu_result = {{(xlen-1){1'b0}}, rs1_data < op_b};
      f3_xor:  alu_result = rs1_data ^ op_b;
      f3_srl:  alu_result = d.alt ? sra_val : rs1_data >> shamt;  // srai has bit 30 set too
      f3_or:   alu_result = rs1_data | op_b;
      default: alu_result = rs1_data & op_b;
    endcase
  end

  // branch comparator, always against rs2
  always_comb begin
    case (d.funct3)
      f3_beq:  cond = rs1_data == rs2_data;
      f3_bne:  cond = rs1_data != rs2_data;
      f3_blt:  cond = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  cond = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: cond = rs1_data < rs2_data;
      f3_bgeu: cond = rs1_data >= rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = (d.op_class == class_branch) && cond;

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  rv_decode_if.rf  d,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data
);

  word_t regs [1:num_regs-1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;  // retire keeps wb_rd nonzero
    end
  end

  // asynchronous reads, a write shows up on the next cycle
  assign rs1_data = (d.rs1 == '0) ? '0 : regs[d.rs1];
  assign rs2_data = (d.rs2 == '0) ? '0 : regs[d.rs2];

endmodule

// File: design/rv_decode.sv
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
  input word_t     insn,
  rv_decode_if.dec d
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign d.rd     = insn[11:7];
  assign d.rs1    = insn[19:15];
  assign d.rs2    = insn[24:20];
  assign d.funct3 = funct3;
  assign d.alt    = insn[30];

  // immediates per format, bit 31 is always the sign
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    d.op_class = class_illegal;
    d.imm = imm_i;
    case (opcode)
      op_lui: begin
        d.op_class = class_lui;
        d.imm = imm_u;
      end
      op_reg_imm: begin
        d.op_class = class_alu_imm;
        if (funct3 == f3_sll && funct7 != 7'd0) begin
          d.op_class = class_illegal;
        end
        if (funct3 == f3_srl && funct7 != 7'd0 && funct7 != alt_funct7) begin
          d.op_class = class_illegal;  // only srli and srai exist here
        end
      end
      op_reg_reg: begin
        if (funct7 == 7'd0) begin
          d.op_class = class_alu_reg;
        end else if (funct7 == alt_funct7 && (funct3 == f3_add || funct3 == f3_srl)) begin
          d.op_class = class_alu_reg;  // sub or sra
        end
      end
      op_branch: begin
        d.imm = imm_b;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          d.op_class = class_branch;
        end
      end
      op_jal: begin
        d.op_class = class_jal;
        d.imm = imm_j;
      end
      op_environ: begin
        if (insn[31:7] == 25'd0) begin
          d.op_class = class_halt;  // ecall, anything else in this group is illegal
        end
      end
      default: d.op_class = class_illegal;
    endcase
  end

endmodule

// File: design/rv_decode_if.sv
`timescale 1ns/100ps

// one decoded instruction, fanned out from decode to the other stages
interface rv_decode_if import rv_pkg::*; ();

  op_class_t  op_class;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  logic [2:0] funct3;
  logic       alt;      // instruction bit 30
  word_t      imm;      // already sign extended for its format

  modport dec (output op_class, rd, rs1, rs2, funct3, alt, imm);

  modport rf (input rs1, rs2);

  modport ex (input op_class, funct3, alt, imm);

  modport ret (input op_class, rd, imm);

endinterface

// File: design/rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  // major opcodes of the kept instruction groups
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // alu funct3, shared by the immediate and register groups
  localparam logic [2:0] f3_add  = 3'b000; // also sub
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // also sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3, 010 and 011 are unused
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] alt_funct7 = 7'b0100000; // selects sub and sra

  // what retire and execute need to know about an instruction
  typedef enum logic [2:0] {
    class_illegal,
    class_lui,
    class_alu_imm,
    class_alu_reg,
    class_branch,
    class_jal,
    class_halt
  } op_class_t;

  localparam word_t pc_step  = 32'd4;
  localparam word_t reset_pc = 32'd0;

endpackage
